/* Makefile */
# Verilator flow for the decode slice testbench
VERILATOR ?= verilator
TOP ?= decodeTb
SEED ?= 21
BUILD ?= obj_dir

.PHONY: sim clean

# Nonzero exit status when the testbench stops with $fatal
sim:
	$(VERILATOR) --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(BUILD) -f flist.f
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(BUILD)

/* flist.f */
verilog/rvDecodePkg.sv
verilog/fetchQueue.sv
verilog/instrDecoder.sv
verilog/decodeStage.sv
verilog/hazardScoreboard.sv
verilog/decodeTop.sv
tb/clockGen.sv
tb/decodeTb.sv

/* tb/clockGen.sv */
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
	parameter int HalfPeriod  = 50,	// 100 ns period
	parameter int ResetCycles = 5
) (
	output logic clk,
	output logic nrst
);

	initial
	begin
		clk = 1'b0;
		forever #(HalfPeriod) clk = ~clk;
	end

	initial
	begin
		nrst = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;	// Released away from the active edge
	end

endmodule

`default_nettype wire

/* tb/decodeTb.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeTb import rvDecodePkg::*;;

	localparam int QueueDepth  = 4;
	localparam int NumDirected = 34;
	localparam int NumRandom   = 60;
	localparam int CycleLimit  = 40 * (NumDirected + NumRandom + 10) + 100;	// 10 for hazard and discard

	// One per supported class, then illegal words
	localparam wordT Directed [NumDirected] = '{
		32'h1234_50B7, 32'hFFFF_F117, 32'h0080_00EF, 32'h0000_8067,	// lui auipc jal jalr
		32'h0020_8463, 32'hFE20_9EE3, 32'h0020_C463, 32'h0020_F463,	// beq bne blt bgeu
		32'h0041_2183, 32'hFFC1_4203, 32'h0031_2423,	// lw lbu sw
		32'hFFF0_8093, 32'h0050_A113, 32'h4032_5213, 32'h0031_1293,	// addi slti srai slli
		32'h4020_81B3, 32'h4020_D1B3, 32'h0020_F233,	// sub sra and
		32'h0220_81B3, 32'h0220_D1B3, 32'h0220_F1B3,	// mul divu remu
		32'h3000_92F3, 32'hB000_2373, 32'h0020_0073,	// csrrw, csrrs read only, uret
		32'h0000_0073, 32'h0010_0073, 32'h3020_0073, 32'h1020_0073,	// ecall ebreak mret sret
		32'h0000_0000, 32'hFFFF_FFFF, 32'h1050_0073,	// Zero, ones, wfi
		32'h0200_9013, 32'h0000_B003, 32'h0000_0013	// Bad slli, ld, nop
	};

	localparam opcodeT OpTable [10] = '{opLoad, opOpImm, opAuipc, opStore, opOp,
		opLui, opBranch, opJalr, opJal, opSystem};

	// funct3 order of OP and OP-IMM
	localparam aluFnT AluByF3 [8] = '{aluAdd, aluSll, aluSlt, aluSltu, aluXor, aluSrl, aluOr, aluAnd};

	// funct3 order of the M extension
	localparam mulDivOpT MdByF3 [8] = '{mdMul, mdMulh, mdMulhsu, mdMulhu,
		mdDiv, mdDivu, mdRem, mdRemu};

	logic clk, nrst;
	logic fetchValid, fetchMisaligned, fetchReady, exReady, wbValid, discard, issueValid;
	wordT fetchPc, fetchInstr, pc, imm;
	regIdxT wbRd, rs1, rs2, rd;
	logic we, branch, branchNeg, jump, jumpReg, lui, auipc;
	logic csrWe, ecall, ebreak, mret, sret, uret, illegal, misaligned;
	aluFnT aluFn;
	fnUnitT fnUnit;
	memOpT memOp;
	mulDivOpT mulDivOp;
	csrAddrT csrAddr;

	wordT stimWord [$], stimPc [$];	// Current batch
	wordT expWord [$], expPc [$];	// Accepted and not yet issued, program order
	logic expMis [$];	// Misaligned flag of each
	regIdxT wbQ [$];	// Issued writers awaiting release
	int nAccepted = 0;
	int batchStart = 0;
	int nIssued = 0;
	int cycles = 0;
	int base;
	bit autoWb = 1'b1;
	wordT nextPc = 32'h0000_1000;
	wordT popWord, popPc, eImm, rndWord;
	regIdxT eRd;
	aluFnT eFn;
	fnUnitT eUnit;
	memOpT eMem;
	mulDivOpT eMd;
	logic [11:0] eFlags;
	logic eWe, eIll, popMis;

	clockGen clock0 (.clk(clk), .nrst(nrst));

	decodeTop #(.QueueDepth(QueueDepth)) dut0 (
		.clk(clk), .nrst(nrst), .fetchValid(fetchValid), .fetchPc(fetchPc),
		.fetchInstr(fetchInstr), .fetchMisaligned(fetchMisaligned), .fetchReady(fetchReady),
		.exReady(exReady), .wbValid(wbValid), .wbRd(wbRd), .discard(discard),
		.issueValid(issueValid), .pc(pc), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
		.we(we), .aluFn(aluFn), .fnUnit(fnUnit), .memOp(memOp), .mulDivOp(mulDivOp),
		.branch(branch), .branchNeg(branchNeg), .jump(jump), .jumpReg(jumpReg), .lui(lui),
		.auipc(auipc), .csrAddr(csrAddr), .csrWe(csrWe), .ecall(ecall), .ebreak(ebreak),
		.mret(mret), .sret(sret), .uret(uret), .illegal(illegal), .misaligned(misaligned)
	);

	task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	// Expected fields straight from the RV32IM encoding tables
	function automatic void refDecode(input wordT w, output regIdxT xRd, output wordT xImm,
		output aluFnT xFn, output logic xWe, output logic xIll, output fnUnitT xUnit,
		output memOpT xMem, output mulDivOpT xMd, output logic [11:0] xFlags);
		logic [2:0] f3;
		logic [6:0] f7;
		logic writes;
		wordT iImm, sImm, bImm, uImm, jImm;
		f3 = w[14:12];
		f7 = w[31:25];
		xRd = w[11:7];
		iImm = {{20{w[31]}}, w[31:20]};
		sImm = {{20{w[31]}}, w[31:25], w[11:7]};
		bImm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		uImm = {w[31:12], 12'h000};
		jImm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		xImm = '0;
		xFn = aluAdd;	// Address math
		xIll = 1'b0;
		writes = 1'b0;
		xUnit = unitAlu;
		xMem = memNone;
		xMd = mdNone;
		// Bits 11..0 hold branch branchNeg jump jumpReg lui auipc csrWe ecall ebreak mret sret uret
		xFlags = '0;
		case (w[6:0])
			opLui:
			begin
				writes = 1'b1;
				xFn = aluPassB;
				xImm = uImm;
				xFlags[7] = 1'b1;
			end
			opAuipc:
			begin
				writes = 1'b1;
				xImm = uImm;
				xFlags[6] = 1'b1;
			end
			opJal:
			begin
				writes = 1'b1;
				xImm = jImm;
				xUnit = unitBranch;
				xFlags[9] = 1'b1;
			end
			opJalr:
			begin
				writes = 1'b1;
				xImm = iImm;
				xUnit = unitBranch;
				xFlags[8] = 1'b1;
				xIll = (f3 != 3'b000);
			end
			opBranch:
			begin
				xImm = bImm;
				xUnit = unitBranch;
				xFlags[11] = 1'b1;
				xFlags[10] = f3[0];	// bne, bge, bgeu
				if (f3[2:1] == 2'b00)
					xFn = aluSub;	// beq, bne
				else if (f3[2:1] == 2'b10)
					xFn = aluSlt;
				else if (f3[2:1] == 2'b11)
					xFn = aluSltu;
				else
					xIll = 1'b1;
			end
			opLoad:
			begin
				writes = 1'b1;
				xImm = iImm;
				xUnit = unitLsu;
				case (f3)
					3'b000:  xMem = memLb;
					3'b001:  xMem = memLh;
					3'b010:  xMem = memLw;
					3'b100:  xMem = memLbu;
					3'b101:  xMem = memLhu;
					default: xIll = 1'b1;
				endcase
			end
			opStore:
			begin
				xImm = sImm;
				xUnit = unitLsu;
				case (f3)
					3'b000:  xMem = memSb;
					3'b001:  xMem = memSh;
					3'b010:  xMem = memSw;
					default: xIll = 1'b1;
				endcase
			end
			opOpImm:
			begin
				writes = 1'b1;
				xImm = iImm;
				xFn = (f3 == 3'b101 && w[30]) ? aluSra : AluByF3[f3];
				if (f3 == 3'b001 && f7 != 7'h00)
					xIll = 1'b1;
				if (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20)
					xIll = 1'b1;
			end
			opOp:
			begin
				writes = 1'b1;
				if (f7 == 7'h00)
					xFn = AluByF3[f3];
				else if (f7 == 7'h20 && f3 == 3'b000)
					xFn = aluSub;
				else if (f7 == 7'h20 && f3 == 3'b101)
					xFn = aluSra;
				else if (f7 == 7'h01)
				begin
					xUnit = unitMulDiv;	// M extension keeps aluAdd
					xMd = MdByF3[f3];
				end
				else
					xIll = 1'b1;
			end
			opSystem:
			begin
				if (f3 == 3'b000)	// ecall, ebreak, xret only
				begin
					xUnit = unitSystem;
					xIll = !(w[19:7] == '0 &&
						(w[31:20] inside {12'h000, 12'h001, 12'h002, 12'h102, 12'h302}));
					case (w[31:20])
						12'h000: xFlags[4] = 1'b1;	// ecall
						12'h001: xFlags[3] = 1'b1;	// ebreak
						12'h002: xFlags[0] = 1'b1;	// uret
						12'h102: xFlags[1] = 1'b1;	// sret
						12'h302: xFlags[2] = 1'b1;	// mret
						default: ;
					endcase
				end
				else if (f3 == 3'b100)
					xIll = 1'b1;
				else
				begin
					writes = 1'b1;	// CSR access
					xUnit = unitCsr;
					// Set and clear forms write only with a nonzero source
					xFlags[5] = (f3 == 3'b001) || (f3 == 3'b101) || (w[19:15] != 5'd0);
				end
			end
			default: xIll = 1'b1;
		endcase
		xWe = writes && !xIll && (xRd != '0);
	endfunction

	task automatic newBatch();
		stimWord.delete();
		stimPc.delete();
		batchStart = nAccepted;
	endtask

	task automatic addWord(input wordT w);
		stimWord.push_back(w);
		stimPc.push_back(nextPc);
		nextPc += 4;
	endtask

	task automatic driveWb();
		if (autoWb && wbQ.size() > 0)
		begin
			wbValid = 1'b1;
			wbRd = wbQ.pop_front();
		end
		else
			wbValid = 1'b0;
	endtask

	// Offers the batch until every word is accepted
	task automatic sendWords(input int validPct, input int readyPct);
		int idx;
		do
		begin
			@(negedge clk);
			idx = nAccepted - batchStart;
			driveWb();
			exReady = ($urandom() % 100) < readyPct;
			fetchValid = (idx < stimWord.size()) && (($urandom() % 100) < validPct);
			if (idx < stimWord.size())
			begin
				fetchInstr = stimWord[idx];
				fetchPc = stimPc[idx];
				fetchMisaligned = 1'($urandom());	// Flag rides along unchanged
			end
		end
		while (nAccepted - batchStart < stimWord.size());
	endtask

	task automatic idleCycle();
		@(negedge clk);
		driveWb();
		exReady = 1'b1;
		fetchValid = 1'b0;
	endtask

	task automatic drainPipe();
		do
			idleCycle();
		while (expWord.size() != 0 || wbQ.size() != 0);
	endtask

	// Compare on issue, then record accepts and discards
	always @(posedge clk)
	begin
		if (nrst)
		begin
			if (!fetchReady)	// Full only with QueueDepth words in flight
				checkEq(expWord.size() >= QueueDepth, 1'b1, "fetchReady low with free entries");
			if (issueValid && exReady)
			begin
				if (expWord.size() == 0)
				begin
					$display("DUT issued an instruction at %0t that was never accepted", $time);
					$display("SOME TESTS FAILED");
					$fatal(1, "Unexpected issue");
				end
				else
				begin
					popWord = expWord.pop_front();
					popPc = expPc.pop_front();
					popMis = expMis.pop_front();
					refDecode(popWord, eRd, eImm, eFn, eWe, eIll, eUnit, eMem, eMd, eFlags);
					checkEq(pc, popPc, "pc");
					checkEq(misaligned, popMis, "misaligned");
					checkEq(rs1, popWord[19:15], "rs1");
					checkEq(rs2, popWord[24:20], "rs2");
					checkEq(csrAddr, popWord[31:20], "csrAddr");
					checkEq(rd, eRd, "rd");
					checkEq(we, eWe, "we");
					checkEq(illegal, eIll, "illegal");
					if (!eIll)
					begin
						checkEq(imm, eImm, "imm");
						checkEq(aluFn, eFn, "aluFn");
						checkEq(fnUnit, eUnit, "fnUnit");
						checkEq(memOp, eMem, "memOp");
						checkEq(mulDivOp, eMd, "mulDivOp");
						checkEq({branch, branchNeg, jump, jumpReg, lui, auipc, csrWe,
							ecall, ebreak, mret, sret, uret}, eFlags, "control flags");
					end
					if (eWe)
						wbQ.push_back(eRd);
					nIssued++;
				end
			end
			if (discard)
			begin
				expWord.delete();
				expPc.delete();
				expMis.delete();
			end
			else if (fetchValid && fetchReady)
			begin
				expWord.push_back(fetchInstr);
				expPc.push_back(fetchPc);
				expMis.push_back(fetchMisaligned);
				nAccepted++;
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > CycleLimit)
		begin
			$display("Timeout after %0d cycles, the DUT stopped issuing", cycles);
			$display("SOME TESTS FAILED");
			$fatal(1, "Timeout");
		end
	end

	initial
	begin
		void'($urandom(21));
		fetchValid = 1'b0;
		fetchPc = '0;
		fetchInstr = '0;
		fetchMisaligned = 1'b0;
		exReady = 1'b0;
		wbValid = 1'b0;
		wbRd = '0;
		discard = 1'b0;
		@(posedge nrst);
		@(negedge clk);
		checkEq(fetchReady, 1'b1, "fetchReady after reset");
		checkEq(issueValid, 1'b0, "issueValid after reset");

		newBatch();
		for (int i = 0; i < NumDirected; i++)
			addWord(Directed[i]);
		sendWords(100, 100);
		drainPipe();

		// Random words on real opcodes, random stalls both sides
		newBatch();
		for (int i = 0; i < NumRandom; i++)
		begin
			rndWord = $urandom();
			rndWord[6:0] = OpTable[$urandom() % 10];
			addWord(rndWord);
		end
		sendWords(70, 60);
		drainPipe();

		autoWb = 1'b0;	// x5 stays pending
		base = nIssued;
		newBatch();
		addWord(32'h0070_0293);	// addi x5, x0, 7
		addWord(32'h0010_8013);	// addi x0, x1, 1
		addWord(32'h0000_03B3);	// add x7, x0, x0
		addWord(32'h0052_8333);	// add x6, x5, x5
		sendWords(100, 100);
		while (nIssued < base + 3)
			idleCycle();
		repeat (10) idleCycle();	// Reader must sit in decode
		checkEq(nIssued, base + 3, "issue count while x5 pending");
		autoWb = 1'b1;	// Releases x5 first
		drainPipe();

		newBatch();
		addWord(32'h0010_0093);
		addWord(32'h0020_0113);
		addWord(32'h0030_0193);
		sendWords(100, 0);	// All parked in queue and decode
		@(negedge clk);
		driveWb();
		exReady = 1'b0;
		fetchValid = 1'b0;
		discard = 1'b1;
		@(negedge clk);
		driveWb();
		discard = 1'b0;
		newBatch();
		addWord(32'h0040_0213);
		addWord(32'h0050_0293);
		addWord(32'h0052_8333);
		sendWords(100, 100);
		drainPipe();

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/decodeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeStage import rvDecodePkg::*; (
	input  logic     clk,
	input  logic     nrst,
	input  logic     qValid,
	input  wordT     qPc,
	input  wordT     qInstr,
	input  logic     qMisaligned,
	output logic     qPop,
	input  logic     decodeHold,
	input  logic     discard,
	output logic     decValid,
	output regIdxT   rs1,
	output regIdxT   rs2,
	output logic     usesRs1,
	output logic     usesRs2,
	output regIdxT   rd,
	output logic     we,
	output wordT     pc,
	output wordT     imm,
	output aluFnT    aluFn,
	output fnUnitT   fnUnit,
	output memOpT    memOp,
	output mulDivOpT mulDivOp,
	output logic     branch,
	output logic     branchNeg,
	output logic     jump,
	output logic     jumpReg,
	output logic     lui,
	output logic     auipc,
	output csrAddrT  csrAddr,
	output logic     csrWe,
	output logic     ecall,
	output logic     ebreak,
	output logic     mret,
	output logic     sret,
	output logic     uret,
	output logic     illegal,
	output logic     misaligned
);

	wordT instrReg;	// Word under decode
	wordT pcReg;
	logic misReg;
	logic validReg;

	// Head is taken whenever the register loads
	assign qPop = qValid && !decodeHold && !discard;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			instrReg <= nopWord;
			pcReg    <= '0;
			misReg   <= 1'b0;
			validReg <= 1'b0;
		end
		else if (discard)	// Flush wins over hold
		begin
			instrReg <= nopWord;
			misReg   <= 1'b0;
			validReg <= 1'b0;
		end
		else if (!decodeHold)
		begin
			if (qValid)
			begin
				instrReg <= qInstr;
				pcReg    <= qPc;
				misReg   <= qMisaligned;
				validReg <= 1'b1;
			end
			else	// Queue empty, insert bubble and keep last pc
			begin
				instrReg <= nopWord;
				misReg   <= 1'b0;
				validReg <= 1'b0;
			end
		end
	end

	assign decValid   = validReg;
	assign pc         = pcReg;
	assign misaligned = misReg;
	assign rs1        = instrReg[19:15];
	assign rs2        = instrReg[24:20];
	assign rd         = instrReg[11:7];
	assign csrAddr    = instrReg[31:20];	// To CSR unit

	instrDecoder decoder0 (
		.instr     (instrReg),
		.usesRs1   (usesRs1),
		.usesRs2   (usesRs2),
		.we        (we),	// Already low for x0
		.aluFn     (aluFn),
		.fnUnit    (fnUnit),
		.memOp     (memOp),
		.mulDivOp  (mulDivOp),
		.immFmt    (),	// Format only matters inside the decoder
		.imm       (imm),
		.branch    (branch),
		.branchNeg (branchNeg),
		.jump      (jump),
		.jumpReg   (jumpReg),
		.lui       (lui),
		.auipc     (auipc),
		.csrWe     (csrWe),
		.ecall     (ecall),
		.ebreak    (ebreak),
		.mret      (mret),
		.sret      (sret),
		.uret      (uret),
		.illegal   (illegal)
	);

endmodule

`default_nettype wire

/* verilog/decodeTop.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeTop import rvDecodePkg::*; #(
	parameter int QueueDepth = 4
) (
	input  logic clk, nrst,
	input  logic fetchValid,
	input  wordT fetchPc, fetchInstr,
	input  logic fetchMisaligned,
	output logic fetchReady,
	input  logic exReady, wbValid,
	input  regIdxT wbRd,
	input  logic discard,
	output logic issueValid,
	output wordT pc,
	output regIdxT rs1, rs2, rd,
	output wordT imm,
	output logic we,
	output aluFnT aluFn,
	output fnUnitT fnUnit,
	output memOpT memOp,
	output mulDivOpT mulDivOp,
	output logic branch, branchNeg, jump, jumpReg, lui, auipc,
	output csrAddrT csrAddr,
	output logic csrWe, ecall, ebreak, mret, sret, uret, illegal, misaligned
);

	logic qValid, qMisaligned, qPop;	// Queue head
	wordT qPc, qInstr;
	logic decValid, usesRs1, usesRs2, decodeHold;

	fetchQueue #(.QueueDepth(QueueDepth)) queue0 (
		.clk(clk), .nrst(nrst), .fetchValid(fetchValid), .fetchPc(fetchPc),
		.fetchInstr(fetchInstr), .fetchMisaligned(fetchMisaligned), .fetchReady(fetchReady),
		.qValid(qValid), .qPc(qPc), .qInstr(qInstr), .qMisaligned(qMisaligned),
		.qPop(qPop), .flush(discard)
	);

	decodeStage decode0 (
		.clk(clk), .nrst(nrst), .qValid(qValid), .qPc(qPc), .qInstr(qInstr),
		.qMisaligned(qMisaligned), .qPop(qPop), .decodeHold(decodeHold), .discard(discard),
		.decValid(decValid), .rs1(rs1), .rs2(rs2), .usesRs1(usesRs1), .usesRs2(usesRs2),
		.rd(rd), .we(we), .pc(pc), .imm(imm), .aluFn(aluFn), .fnUnit(fnUnit),
		.memOp(memOp), .mulDivOp(mulDivOp), .branch(branch), .branchNeg(branchNeg),
		.jump(jump), .jumpReg(jumpReg), .lui(lui), .auipc(auipc), .csrAddr(csrAddr),
		.csrWe(csrWe), .ecall(ecall), .ebreak(ebreak), .mret(mret), .sret(sret),
		.uret(uret), .illegal(illegal), .misaligned(misaligned)
	);

	hazardScoreboard scoreboard0 (
		.clk(clk), .nrst(nrst), .decValid(decValid), .rs1(rs1), .rs2(rs2),
		.usesRs1(usesRs1), .usesRs2(usesRs2), .rd(rd), .we(we), .exReady(exReady),
		.wbValid(wbValid), .wbRd(wbRd), .issueValid(issueValid), .decodeHold(decodeHold)
	);

endmodule

`default_nettype wire

/* verilog/fetchQueue.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchQueue import rvDecodePkg::*; #(
	parameter int QueueDepth = 4	// Two or more entries
) (
	input  logic clk,
	input  logic nrst,
	input  logic fetchValid,
	input  wordT fetchPc,
	input  wordT fetchInstr,
	input  logic fetchMisaligned,
	output logic fetchReady,
	output logic qValid,
	output wordT qPc,
	output wordT qInstr,
	output logic qMisaligned,
	input  logic qPop,
	input  logic flush
);

	localparam int PtrW = $clog2(QueueDepth);
	localparam int CntW = $clog2(QueueDepth + 1);

	wordT pcMem [QueueDepth];	// Payload storage
	wordT instrMem [QueueDepth];
	logic misMem [QueueDepth];

	logic [PtrW-1:0] wrPtr, rdPtr;
	logic [CntW-1:0] count;	// Occupied entries
	logic push, pop;

	assign fetchReady = (count != CntW'(QueueDepth));
	assign qValid     = (count != '0);
	assign push       = fetchValid && fetchReady;
	assign pop        = qPop && qValid;

	// Head entry
	assign qPc         = pcMem[rdPtr];
	assign qInstr      = instrMem[rdPtr];
	assign qMisaligned = misMem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (push && !flush)
		begin
			pcMem[wrPtr]    <= fetchPc;
			instrMem[wrPtr] <= fetchInstr;
			misMem[wrPtr]   <= fetchMisaligned;
		end
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else if (flush)	// Empties the queue, a word pushed on this edge is dropped too
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= (wrPtr == PtrW'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;	// Wrap
			if (pop)
				rdPtr <= (rdPtr == PtrW'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Idle or push with pop
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/hazardScoreboard.sv */
`timescale 1ns/10ps
`default_nettype none

module hazardScoreboard import rvDecodePkg::*; (
	input  logic   clk,
	input  logic   nrst,
	input  logic   decValid,
	input  regIdxT rs1,
	input  regIdxT rs2,
	input  logic   usesRs1,
	input  logic   usesRs2,
	input  regIdxT rd,
	input  logic   we,
	input  logic   exReady,
	input  logic   wbValid,
	input  regIdxT wbRd,
	output logic   issueValid,
	output logic   decodeHold
);

	logic [31:0] pending;	// One bit per register, bit 0 never set
	logic rs1Busy, rs2Busy;
	logic issue;

	// A writeback in this cycle already releases the source
	assign rs1Busy = usesRs1 && pending[rs1] && !(wbValid && wbRd == rs1);
	assign rs2Busy = usesRs2 && pending[rs2] && !(wbValid && wbRd == rs2);

	assign issueValid = decValid && !rs1Busy && !rs2Busy;
	assign issue      = issueValid && exReady;	// Handshake with execute
	assign decodeHold = decValid && !issue;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			pending <= '0;
		else
		begin
			for (int i = 1; i < 32; i++)
			begin
				if (issue && we && rd == regIdxT'(i))	// New writer wins over release
					pending[i] <= 1'b1;
				else if (wbValid && wbRd == regIdxT'(i))
					pending[i] <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instrDecoder import rvDecodePkg::*; (
	input  wordT     instr,
	output logic     usesRs1,
	output logic     usesRs2,
	output logic     we,
	output aluFnT    aluFn,
	output fnUnitT   fnUnit,
	output memOpT    memOp,
	output mulDivOpT mulDivOp,
	output immFmtT   immFmt,
	output wordT     imm,
	output logic     branch,
	output logic     branchNeg,
	output logic     jump,
	output logic     jumpReg,
	output logic     lui,
	output logic     auipc,
	output logic     csrWe,
	output logic     ecall,
	output logic     ebreak,
	output logic     mret,
	output logic     sret,
	output logic     uret,
	output logic     illegal
);

	opcodeT      opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [11:0] funct12;
	regIdxT      rd;
	regIdxT      rs1Field;	// Also zimm of CSR immediate forms
	logic        weRaw;

	assign opcode   = instr[6:0];
	assign rd       = instr[11:7];
	assign funct3   = instr[14:12];
	assign rs1Field = instr[19:15];
	assign funct7   = instr[31:25];
	assign funct12  = instr[31:20];

	// Shared OP and OP-IMM mapping, alt selects sub or sra
	function automatic aluFnT aluFromF3(input logic [2:0] f3, input logic alt);
		aluFnT fn;
		case (f3)
			3'b000:  fn = alt ? aluSub : aluAdd;
			3'b001:  fn = aluSll;
			3'b010:  fn = aluSlt;
			3'b011:  fn = aluSltu;
			3'b100:  fn = aluXor;
			3'b101:  fn = alt ? aluSra : aluSrl;
			3'b110:  fn = aluOr;
			default: fn = aluAnd;
		endcase
		return fn;
	endfunction

	always_comb
	begin
		usesRs1 = 1'b0;
		usesRs2 = 1'b0;
		weRaw = 1'b0;
		aluFn = aluAdd;	// Address and pc math default
		fnUnit = unitAlu;
		memOp = memNone;
		mulDivOp = mdNone;
		immFmt = immNone;
		branch = 1'b0;
		branchNeg = 1'b0;
		jump = 1'b0;
		jumpReg = 1'b0;
		lui = 1'b0;
		auipc = 1'b0;
		csrWe = 1'b0;
		ecall = 1'b0;
		ebreak = 1'b0;
		mret = 1'b0;
		sret = 1'b0;
		uret = 1'b0;
		illegal = 1'b0;
		case (opcode)
			opLui:
			begin
				weRaw = 1'b1; aluFn = aluPassB; immFmt = immU; lui = 1'b1;
			end
			opAuipc:
			begin
				weRaw = 1'b1; immFmt = immU; auipc = 1'b1;	// pc + imm
			end
			opJal:
			begin
				weRaw = 1'b1; fnUnit = unitBranch; immFmt = immJ; jump = 1'b1;
			end
			opJalr:
			begin
				usesRs1 = 1'b1; weRaw = 1'b1; fnUnit = unitBranch; immFmt = immI; jumpReg = 1'b1;
				illegal = (funct3 != 3'b000);
			end
			opBranch:
			begin
				usesRs1 = 1'b1; usesRs2 = 1'b1; fnUnit = unitBranch; immFmt = immB; branch = 1'b1;
				branchNeg = funct3[0];	// bne, bge, bgeu invert the compare
				case (funct3[2:1])
					2'b00:   aluFn = aluSub;	// Equality
					2'b10:   aluFn = aluSlt;
					2'b11:   aluFn = aluSltu;
					default: illegal = 1'b1;
				endcase
			end
			opLoad:
			begin
				usesRs1 = 1'b1; weRaw = 1'b1; fnUnit = unitLsu; immFmt = immI;
				case (funct3)
					3'b000:  memOp = memLb;
					3'b001:  memOp = memLh;
					3'b010:  memOp = memLw;
					3'b100:  memOp = memLbu;
					3'b101:  memOp = memLhu;
					default: illegal = 1'b1;
				endcase
			end
			opStore:
			begin
				usesRs1 = 1'b1; usesRs2 = 1'b1; fnUnit = unitLsu; immFmt = immS;
				case (funct3)
					3'b000:  memOp = memSb;
					3'b001:  memOp = memSh;
					3'b010:  memOp = memSw;
					default: illegal = 1'b1;
				endcase
			end
			opOpImm:
			begin
				usesRs1 = 1'b1; weRaw = 1'b1; immFmt = immI;
				aluFn = aluFromF3(funct3, (funct3 == 3'b101) && instr[30]);
				if (funct3 == 3'b001 && funct7 != 7'b000_0000)	// slli shamt only
					illegal = 1'b1;
				if (funct3 == 3'b101 && funct7 != 7'b000_0000 && funct7 != 7'b010_0000)
					illegal = 1'b1;
			end
			opOp:
			begin
				usesRs1 = 1'b1; usesRs2 = 1'b1; weRaw = 1'b1;
				case (funct7)
					7'b000_0000: aluFn = aluFromF3(funct3, 1'b0);
					7'b010_0000:
					begin
						aluFn = aluFromF3(funct3, 1'b1);
						illegal = (funct3 != 3'b000) && (funct3 != 3'b101);	// sub, sra only
					end
					7'b000_0001:	// M extension
					begin
						fnUnit = unitMulDiv;
						mulDivOp = mulDivOpT'(4'(funct3) + 4'd1);
					end
					default: illegal = 1'b1;
				endcase
			end
			opSystem:
			begin
				if (funct3 == 3'b000)
				begin
					fnUnit = unitSystem;
					illegal = (rs1Field != '0) || (rd != '0);
					case (funct12)
						12'h000: ecall = 1'b1;
						12'h001: ebreak = 1'b1;
						12'h002: uret = 1'b1;
						12'h102: sret = 1'b1;
						12'h302: mret = 1'b1;
						default: illegal = 1'b1;	// wfi included
					endcase
				end
				else if (funct3 == 3'b100)
					illegal = 1'b1;
				else
				begin
					fnUnit = unitCsr; weRaw = 1'b1;
					usesRs1 = !funct3[2];	// Register forms only
					csrWe = (funct3[1:0] == 2'b01) || (rs1Field != '0);	// csrrs/c with x0 only read
				end
			end
			default: illegal = 1'b1;
		endcase
	end

	assign we = weRaw && !illegal && (rd != '0);

	always_comb
	begin
		case (immFmt)
			immI:    imm = {{20{instr[31]}}, instr[31:20]};
			immS:    imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			immB:    imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			immU:    imm = {instr[31:12], 12'b0};
			immJ:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			default: imm = '0;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/rvDecodePkg.sv */
`default_nettype none

package rvDecodePkg;

	typedef logic [31:0] wordT;	// Instruction word, pc or immediate
	typedef logic [4:0]  regIdxT;	// Architectural register index
	typedef logic [6:0]  opcodeT;
	typedef logic [11:0] csrAddrT;

	// ALU operation, also reused for branch compares
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu,
		aluXor, aluSrl, aluSra, aluOr, aluAnd,
		aluPassB	// Operand B straight through (lui)
	} aluFnT;

	// Function unit that takes the instruction in execute
	typedef enum logic [2:0] {
		unitAlu, unitBranch, unitLsu, unitMulDiv, unitCsr, unitSystem
	} fnUnitT;

	typedef enum logic [3:0] {
		memNone,
		memLb, memLh, memLw, memLbu, memLhu,	// Loads
		memSb, memSh, memSw	// Stores
	} memOpT;

	// Order follows funct3, offset by one for mdNone
	typedef enum logic [3:0] {
		mdNone,
		mdMul, mdMulh, mdMulhsu, mdMulhu,
		mdDiv, mdDivu, mdRem, mdRemu
	} mulDivOpT;

	typedef enum logic [2:0] {
		immNone, immI, immS, immB, immU, immJ
	} immFmtT;

	// addi x0, x0, 0
	localparam wordT nopWord = 32'h0000_0013;

	// Major opcodes, low two bits always 11 for 32-bit encodings
	localparam opcodeT opLoad   = 7'b000_0011;
	localparam opcodeT opOpImm  = 7'b001_0011;
	localparam opcodeT opAuipc  = 7'b001_0111;
	localparam opcodeT opStore  = 7'b010_0011;
	localparam opcodeT opOp     = 7'b011_0011;
	localparam opcodeT opLui    = 7'b011_0111;
	localparam opcodeT opBranch = 7'b110_0011;
	localparam opcodeT opJalr   = 7'b110_0111;
	localparam opcodeT opJal    = 7'b110_1111;
	localparam opcodeT opSystem = 7'b111_0011;	// ecall, ebreak, xret, CSR

endpackage

`default_nettype wire
